/* build.f */
lcdPkg.sv
lcdByteIf.sv
textBuffer.sv
displaySequencer.sv
nibbleWriter.sv
lcdController.sv
tbClockGen.sv
lcdControllerTb.sv

/* Bender.yml */
package:
  name: lcd_controller

sources:
  - lcdPkg.sv
  - lcdByteIf.sv
  - textBuffer.sv
  - displaySequencer.sv
  - nibbleWriter.sv
  - lcdController.sv
  - target: test
    files:
      - tbClockGen.sv
      - lcdControllerTb.sv

/* lcdControllerTb.sv */
module lcdControllerTb
    import lcdPkg::*;
();

    localparam int clkPeriod      = 8;
    localparam int stepLen        = 4;
    localparam int resetCycles    = 10;
    localparam int nibbleCycles   = 3*stepLen + 1;
    localparam int byteCycles     = 6*stepLen + 1;
    localparam int initCycles     = 4*nibbleCycles + 4*byteCycles;
    localparam int frameCycles    = 34*byteCycles;
    localparam int watchdogCycles = 2*(resetCycles + initCycles + 4*frameCycles);
    // char 0 is fetched two steps before the address command reaches E
    localparam time fetchLead     = 2*stepLen*clkPeriod;

    logic       clk;
    logic       reset;
    logic       cyc;
    logic       stb;
    logic       we;
    charAddr_t  adr;
    lcdByte_t   datW;
    lcdByte_t   datR;
    logic       ack;
    lcdNibble_t lcdData;
    logic       lcdRs;
    logic       lcdE;

    // pins seen at each E pulse
    lcdNibble_t nibQ [$];
    logic       rsQ [$];
    time        riseQ [$];
    int         gapQ [$];
    int         highQ [$];
    time        lastRise;
    time        lastFall;
    time        lastWrite;
    lcdByte_t   shadow [32];

    tbClockGen #(.period(clkPeriod)) u_clockGen (.clk(clk));

    lcdController #(.stepCycles(stepLen)) u_dut (
        .clk(clk), .reset(reset),
        .cyc(cyc), .stb(stb), .we(we), .adr(adr), .datW(datW), .datR(datR), .ack(ack),
        .lcdData(lcdData), .lcdRs(lcdRs), .lcdE(lcdE)
    );

    ////////////////////////////////////////////////////////////
    // LCD monitor
    ////////////////////////////////////////////////////////////

    always @(posedge lcdE) begin
        nibQ.push_back(lcdData);
        rsQ.push_back(lcdRs);
        riseQ.push_back($time);
        gapQ.push_back(int'(($time - lastFall) / clkPeriod));
        lastRise = $time;
    end

    always @(negedge lcdE) begin
        if (riseQ.size() > 0) begin
            highQ.push_back(int'(($time - lastRise) / clkPeriod));
        end
        lastFall = $time;
    end

    initial begin
        repeat (watchdogCycles) @(posedge clk);
        $display("run timed out after %0d cycles before the tests finished", watchdogCycles);
        $display("TB FAILED");
        $fatal(1, "watchdog expired");
    end

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////

    task automatic expectEqual(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("[FAIL] t=%0t %s: got 0x%0h, expected 0x%0h", $time, what, actual, expected);
            $display("TB FAILED");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    // byte k follows the four power-on nibbles
    function automatic lcdByte_t byteAt(input int k);
        return {nibQ[4 + 2*k], nibQ[5 + 2*k]};
    endfunction

    task automatic waitBytes(input int count);
        while (nibQ.size() < 4 + 2*count) @(posedge clk);
    endtask

    task automatic checkByte(input int k, input lcdByte_t value, input logic rs, input string what);
        expectEqual(byteAt(k), value, what);
        expectEqual(rsQ[4 + 2*k], rs, {what, " rs on high nibble"});
        expectEqual(rsQ[5 + 2*k], rs, {what, " rs on low nibble"});
    endtask

    task automatic wbWrite(input charAddr_t addr, input lcdByte_t data);
        @(negedge clk);
        expectEqual(ack, 0, "ack idle before write");
        cyc  = 1'b1;
        stb  = 1'b1;
        we   = 1'b1;
        adr  = addr;
        datW = data;
        @(negedge clk);
        expectEqual(ack, 1, $sformatf("write ack one cycle after request, adr %0d", addr));
        @(negedge clk);
        expectEqual(ack, 0, "write ack lasts one cycle");
        cyc       = 1'b0;
        stb       = 1'b0;
        we        = 1'b0;
        lastWrite = $time;
    endtask

    task automatic wbRead(input charAddr_t addr, input lcdByte_t expected);
        @(negedge clk);
        expectEqual(ack, 0, "ack idle before read");
        cyc = 1'b1;
        stb = 1'b1;
        we  = 1'b0;
        adr = addr;
        @(negedge clk);
        expectEqual(ack, 1, $sformatf("read ack one cycle after request, adr %0d", addr));
        expectEqual(datR, expected, $sformatf("read back adr %0d", addr));
        @(negedge clk);
        expectEqual(ack, 0, "read ack lasts one cycle");
        cyc = 1'b0;
        stb = 1'b0;
    endtask

    // first frame whose address command strobes after the given time
    task automatic waitFrame(input time after, output int first);
        int k;
        first = -1;
        k     = 0;
        while (first < 0) begin
            waitBytes(k + 1);
            if (byteAt(k) == 8'h80 && rsQ[4 + 2*k] == 1'b0 && riseQ[4 + 2*k] > after) begin
                first = k;
            end
            k++;
        end
        waitBytes(first + 34);
    endtask

    task automatic checkFrame(input int first, input string what);
        checkByte(first, 8'h80, 1'b0, {what, " line 0 address"});
        for (int c = 0; c < 16; c++) begin
            checkByte(first + 1 + c, shadow[c], 1'b1, $sformatf("%s line 0 col %0d", what, c));
        end
        checkByte(first + 17, 8'hC0, 1'b0, {what, " line 1 address"});
        for (int c = 0; c < 16; c++) begin
            checkByte(first + 18 + c, shadow[16 + c], 1'b1,
                      $sformatf("%s line 1 col %0d", what, c));
        end
    endtask

    ////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////

    task automatic testReset();
        repeat (resetCycles) @(posedge clk);
        @(negedge clk);
        expectEqual(lcdE, 0, "lcdE after reset");
        expectEqual(lcdRs, 0, "lcdRs after reset");
        expectEqual(lcdData, 0, "lcdData after reset");
        expectEqual(ack, 0, "ack after reset");
        reset = 1'b0;
        repeat (stepLen) begin
            @(negedge clk);
            expectEqual(lcdE, 0, "lcdE low in first step after reset");
        end
    endtask

    task automatic testInit();
        waitBytes(4);
        for (int i = 0; i < 3; i++) begin
            expectEqual(nibQ[i], 4'h3, $sformatf("wake nibble %0d", i));
            expectEqual(rsQ[i], 0, $sformatf("wake nibble %0d rs", i));
        end
        expectEqual(nibQ[3], 4'h2, "mode nibble");
        expectEqual(rsQ[3], 0, "mode nibble rs");
        checkByte(0, 8'h28, 1'b0, "function set");
        checkByte(1, 8'h06, 1'b0, "entry mode");
        checkByte(2, 8'h0C, 1'b0, "display on");
        checkByte(3, 8'h01, 1'b0, "clear");
    endtask

    task automatic testBlankFrame();
        int first;
        for (int a = 0; a < 32; a++) begin
            shadow[a] = 8'h20;
        end
        waitFrame(0, first);
        checkFrame(first, "blank frame");
    endtask

    task automatic testWishbone();
        for (int a = 0; a < 32; a++) begin
            shadow[a] = lcdByte_t'($urandom_range(126, 33));
            wbWrite(charAddr_t'(a), shadow[a]);
        end
        for (int a = 0; a < 32; a++) begin
            wbRead(charAddr_t'(a), shadow[a]);
        end
    endtask

    task automatic testRefreshFrame();
        int first;
        waitFrame(lastWrite + fetchLead, first);
        checkFrame(first, "refresh frame");
    endtask

    task automatic testUpdate();
        int       first;
        int       addr;
        lcdByte_t newChar;
        addr    = $urandom_range(31, 0);
        newChar = lcdByte_t'($urandom_range(126, 33));
        if (newChar == shadow[addr]) begin
            newChar = newChar ^ 8'h01;
        end
        shadow[addr] = newChar;
        wbWrite(charAddr_t'(addr), newChar);
        waitFrame(lastWrite + fetchLead, first);
        checkFrame(first, "updated frame");
    endtask

    // E high one step, low two steps between the nibbles of a byte
    task automatic testETiming();
        for (int i = 0; i < highQ.size(); i++) begin
            expectEqual(highQ[i], stepLen, $sformatf("E high width, pulse %0d", i));
        end
        for (int i = 5; i < gapQ.size(); i += 2) begin
            expectEqual(gapQ[i], 2*stepLen, $sformatf("E low inside byte, pulse %0d", i));
        end
    endtask

    initial begin
        void'($urandom(32'h7c79));
        reset     = 1'b1;
        cyc       = 1'b0;
        stb       = 1'b0;
        we        = 1'b0;
        adr       = '0;
        datW      = '0;
        lastRise  = 0;
        lastFall  = 0;
        lastWrite = 0;
        testReset();
        testInit();
        testBlankFrame();
        testWishbone();
        testRefreshFrame();
        testUpdate();
        testETiming();
        $display("TB PASSED");
        $finish;
    end

endmodule

/* tbClockGen.sv */
module tbClockGen #(
    parameter int period = 8
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(period / 2);
            clk = ~clk;
        end
    end

endmodule

/* lcdController.sv */
module lcdController
    import lcdPkg::*;
#(
    parameter int stepCycles = lcdStepCycles
) (
    input  logic       clk,
    input  logic       reset,

    // wishbone classic slave
    input  logic       cyc,
    input  logic       stb,
    input  logic       we,
    input  charAddr_t  adr,
    input  lcdByte_t   datW,
    output lcdByte_t   datR,
    output logic       ack,

    // display pins, R/W is tied low on the board
    output lcdNibble_t lcdData,
    output logic       lcdRs,
    output logic       lcdE
);

    charAddr_t readAddr;
    lcdByte_t  readChar;

    lcdByteIf byteLink ();

    textBuffer u_textBuffer (
        .clk      (clk),
        .reset    (reset),
        .cyc      (cyc),
        .stb      (stb),
        .we       (we),
        .adr      (adr),
        .datW     (datW),
        .datR     (datR),
        .ack      (ack),
        .readAddr (readAddr),
        .readChar (readChar)
    );

    displaySequencer u_displaySequencer (
        .clk      (clk),
        .reset    (reset),
        .readChar (readChar),
        .readAddr (readAddr),
        .byteOut  (byteLink.source)
    );

    nibbleWriter #(
        .stepCycles (stepCycles)
    ) u_nibbleWriter (
        .clk     (clk),
        .reset   (reset),
        .byteIn  (byteLink.sink),
        .lcdData (lcdData),
        .lcdRs   (lcdRs),
        .lcdE    (lcdE)
    );

endmodule

/* nibbleWriter.sv */
module nibbleWriter
    import lcdPkg::*;
#(
    parameter int stepCycles = lcdStepCycles
) (
    input  logic       clk,
    input  logic       reset,

    lcdByteIf.sink     byteIn,

    output lcdNibble_t lcdData,
    output logic       lcdRs,
    output logic       lcdE
);

    localparam int stepWidth = $clog2(stepCycles + 1);

    writerState_t state;

    logic [stepWidth-1:0] stepCount;
    logic                 stepDone;

    lcdByte_t byteReg;
    logic     rsReg;
    // set once the high nibble is out, or from the start for nibbleOnly
    logic     lowPhase;

    assign byteIn.ready = (state == wrIdle);
    assign stepDone     = (stepCount == stepWidth'(stepCycles - 1));

    ////////////////////////////////////////////////////////////
    // step timer
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            stepCount <= '0;
        end else if (state == wrIdle || stepDone) begin
            stepCount <= '0;
        end else begin
            stepCount <= stepCount + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // E low, data setup, E high for each nibble
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= wrIdle;
            lowPhase <= 1'b0;
            lcdData  <= '0;
            lcdRs    <= 1'b0;
            lcdE     <= 1'b0;
        end else begin
            case (state)
                wrIdle: begin
                    if (byteIn.valid) begin
                        state    <= wrHold;
                        lowPhase <= byteIn.nibbleOnly;
                    end
                end
                wrHold: begin
                    if (stepDone) begin
                        state   <= wrSetup;
                        lcdData <= lowPhase ? byteReg[3:0] : byteReg[7:4];
                        lcdRs   <= rsReg;
                    end
                end
                wrSetup: begin
                    if (stepDone) begin
                        state <= wrPulse;
                        lcdE  <= 1'b1;
                    end
                end
                default: begin
                    if (stepDone) begin
                        lcdE <= 1'b0;
                        if (lowPhase) begin
                            state <= wrIdle;
                        end else begin
                            state    <= wrHold;
                            lowPhase <= 1'b1;
                        end
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == wrIdle && byteIn.valid) begin
            byteReg <= byteIn.data;
            rsReg   <= byteIn.rs;
        end
    end

endmodule

/* displaySequencer.sv */
module displaySequencer
    import lcdPkg::*;
(
    input  logic       clk,
    input  logic       reset,

    input  lcdByte_t   readChar,
    output charAddr_t  readAddr,

    lcdByteIf.source   byteOut
);

    seqState_t state;

    // column in seqChars, item index during init
    logic [3:0] column;
    logic       line;

    lcdByte_t configByte;
    lcdByte_t nextData;
    logic     nextRs;
    logic     nextNibbleOnly;
    logic     accepted;

    assign readAddr = {line, column};
    assign accepted = byteOut.valid && byteOut.ready;

    always_comb begin
        case (column[1:0])
            2'd0:    configByte = lcdCmdFunctionSet;
            2'd1:    configByte = lcdCmdEntryMode;
            2'd2:    configByte = lcdCmdDisplayOn;
            default: configByte = lcdCmdClear;
        endcase
    end

    // what the current state wants to send next
    always_comb begin
        nextData       = configByte;
        nextRs         = 1'b0;
        nextNibbleOnly = 1'b0;
        case (state)
            seqWake: begin
                nextData       = {4'h0, lcdWakeNibble};
                nextNibbleOnly = 1'b1;
            end
            seqMode: begin
                nextData       = {4'h0, lcdModeNibble};
                nextNibbleOnly = 1'b1;
            end
            seqLineAddr: begin
                nextData = line ? lcdCmdLine1Addr : lcdCmdLine0Addr;
            end
            seqChars: begin
                nextData = readChar;
                nextRs   = 1'b1;
            end
            default: ;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // present, wait for the writer, then advance
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state         <= seqWake;
            column        <= '0;
            line          <= 1'b0;
            byteOut.valid <= 1'b0;
        end else if (!byteOut.valid) begin
            byteOut.valid <= 1'b1;
        end else if (accepted) begin
            byteOut.valid <= 1'b0;
            column        <= column + 4'd1;
            case (state)
                seqWake: begin
                    if (column == 4'(lcdWakeCount - 1)) begin
                        state  <= seqMode;
                        column <= '0;
                    end
                end
                seqMode: begin
                    state  <= seqConfig;
                    column <= '0;
                end
                seqConfig: begin
                    if (column == 4'(lcdConfigCount - 1)) begin
                        state  <= seqLineAddr;
                        column <= '0;
                    end
                end
                seqLineAddr: begin
                    state  <= seqChars;
                    column <= '0;
                end
                default: begin
                    // last column wraps to the other line
                    if (column == 4'(lcdLineChars - 1)) begin
                        state <= seqLineAddr;
                        line  <= !line;
                    end
                end
            endcase
        end
    end

    // byte is sampled once, held until the writer takes it
    always_ff @(posedge clk) begin
        if (!byteOut.valid) begin
            byteOut.data       <= nextData;
            byteOut.rs         <= nextRs;
            byteOut.nibbleOnly <= nextNibbleOnly;
        end
    end

endmodule

/* textBuffer.sv */
module textBuffer
    import lcdPkg::*;
(
    input  logic      clk,
    input  logic      reset,

    // wishbone classic slave
    input  logic      cyc,
    input  logic      stb,
    input  logic      we,
    input  charAddr_t adr,
    input  lcdByte_t  datW,
    output lcdByte_t  datR,
    output logic      ack,

    // sequencer read port
    input  charAddr_t readAddr,
    output lcdByte_t  readChar
);

    lcdByte_t chars [2*lcdLineChars];

    logic request;

    assign request = cyc && stb;

    ////////////////////////////////////////////////////////////
    // bus side
    ////////////////////////////////////////////////////////////

    // ack one cycle after the request, then drop for a cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            ack <= 1'b0;
        end else begin
            ack <= request && !ack;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 2*lcdLineChars; i++) begin
                chars[i] <= lcdBlankChar;
            end
        end else if (request && we && ack) begin
            chars[adr] <= datW;
        end
    end

    // captured on the request cycle, valid while ack is high
    always_ff @(posedge clk) begin
        if (request && !ack) begin
            datR <= chars[adr];
        end
    end

    ////////////////////////////////////////////////////////////
    // display side
    ////////////////////////////////////////////////////////////

    assign readChar = chars[readAddr];

endmodule

/* lcdByteIf.sv */
interface lcdByteIf
    import lcdPkg::*;
();

    lcdByte_t data;
    logic     rs;
    // only data[3:0] goes out
    logic     nibbleOnly;
    logic     valid;
    logic     ready;

    modport source (
        output data, rs, nibbleOnly, valid,
        input  ready
    );

    modport sink (
        input  data, rs, nibbleOnly, valid,
        output ready
    );

endinterface

/* lcdPkg.sv */
package lcdPkg;

    ////////////////////////////////////////////////////////////
    // widths
    ////////////////////////////////////////////////////////////

    typedef logic [3:0] lcdNibble_t;
    typedef logic [7:0] lcdByte_t;

    // top bit picks the line, low four the column
    typedef logic [4:0] charAddr_t;

    ////////////////////////////////////////////////////////////
    // HD44780 commands
    ////////////////////////////////////////////////////////////

    // 4-bit bus, two lines, 5x8 font
    localparam lcdByte_t lcdCmdFunctionSet = 8'h28;
    localparam lcdByte_t lcdCmdEntryMode   = 8'h06;
    localparam lcdByte_t lcdCmdDisplayOn   = 8'h0C;
    localparam lcdByte_t lcdCmdClear       = 8'h01;
    localparam lcdByte_t lcdCmdLine0Addr   = 8'h80;
    localparam lcdByte_t lcdCmdLine1Addr   = 8'hC0;

    // power-on nibbles, sent before the bus is in 4-bit mode
    localparam lcdNibble_t lcdWakeNibble = 4'h3;
    localparam lcdNibble_t lcdModeNibble = 4'h2;
    localparam int         lcdWakeCount  = 3;

    // function set, entry mode, display on, clear
    localparam int lcdConfigCount = 4;

    localparam int       lcdLineChars = 16;
    localparam lcdByte_t lcdBlankChar = 8'h20;

    // clock cycles per E step
    localparam int lcdStepCycles = 10000;

    ////////////////////////////////////////////////////////////
    // state machines
    ////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        seqWake,
        seqMode,
        seqConfig,
        seqLineAddr,
        seqChars
    } seqState_t;

    typedef enum logic [1:0] {
        wrIdle,
        wrSetup,
        wrPulse,
        wrHold
    } writerState_t;

endpackage
